/* Bender.yml */
package:
  name: msr_unit

sources:
  # Package first, then the pipeline stages and the top level
  - msr_pkg.sv
  - msr_decode.sv
  - tsc_timer.sv
  - msr_execute.sv
  - msr_result.sv
  - msr_unit_top.sv
  # Testbench, top module tb_msr_unit
  - target: test
    files:
      - tb_msr_unit.sv

/* build.f */
msr_pkg.sv
msr_decode.sv
tsc_timer.sv
msr_execute.sv
msr_result.sv
msr_unit_top.sv
tb_msr_unit.sv

/* msr_decode.sv */
// ======================================
// Decode stage, registers each command
// and maps its address to a register select
// ======================================
`timescale 1ns/1ns
`default_nettype none

module msr_decode (
   input  logic               clk,
   input  logic               rst,
   input  logic               cmd_valid,
   input  msr_pkg::msr_cmd_t  cmd,
   output logic               dec_valid,
   output msr_pkg::msr_dec_t  dec
);

   import msr_pkg::*;

   msr_dec_t          dec_nxt;
   logic [ADDR_W-1:0] scr_off;

   // Offset into the scratch bank
   assign scr_off = cmd.addr - MSR_SCR0;

   // Address classification
   always_comb begin
      dec_nxt.op    = cmd.op;
      dec_nxt.wdata = cmd.wdata;
      dec_nxt.idx   = '0;
      if (cmd.addr == MSR_TSR) begin
         dec_nxt.sel = SEL_TSR;
      end else if (cmd.addr == MSR_TCR) begin
         dec_nxt.sel = SEL_TCR;
      end else if (scr_off < SCR_NUM) begin
         // Scratch range, wraps below MSR_SCR0 land above SCR_NUM
         dec_nxt.sel = SEL_SCR;
         dec_nxt.idx = scr_off[SCR_IW-1:0];
      end else begin
         // Anything past the last scratch register
         dec_nxt.sel = SEL_NONE;
      end
   end

   // Valid flag
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= cmd_valid;
      end
   end

   // Payload, loaded only on an accepted command
   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         dec <= dec_nxt;
      end
   end

endmodule

`default_nettype wire

/* msr_execute.sv */
// ======================================
// Execute stage, read-modify-write on the
// MSR bank and response register
// Holds scratch MSRs and the time-stamp counter
// ======================================
`timescale 1ns/1ns
`default_nettype none

module msr_execute (
   input  logic               clk,
   input  logic               rst,
   input  logic               dec_valid,
   input  msr_pkg::msr_dec_t  dec,
   output logic               ex_valid,
   output msr_pkg::msr_rsp_t  ex_rsp,
   output logic               tsc_irq
);

   import msr_pkg::*;

   logic [DATA_W-1:0] scr [SCR_NUM];
   logic [DATA_W-1:0] tsr;
   logic [DATA_W-1:0] tcr;
   logic [DATA_W-1:0] old_val;
   logic [DATA_W-1:0] new_val;
   logic              do_write;
   logic              tsr_we;
   logic              tcr_we;
   logic              scr_we;
   msr_rsp_t          rsp_nxt;

   // Old value mux, unmapped reads as zero
   always_comb begin
      case (dec.sel)
         SEL_TSR: old_val = tsr;
         SEL_TCR: old_val = tcr;
         SEL_SCR: old_val = scr[dec.idx];
         default: old_val = '0;
      endcase
   end

   // New value per opcode
   always_comb begin
      case (dec.op)
         MSR_WRITE: new_val = dec.wdata;
         MSR_SET:   new_val = old_val | dec.wdata;
         MSR_CLR:   new_val = old_val & ~dec.wdata;
         default:   new_val = old_val;
      endcase
   end

   // Reads and bad addresses write nothing
   assign do_write = dec_valid && (dec.op != MSR_READ) && (dec.sel != SEL_NONE);
   assign tsr_we   = do_write && (dec.sel == SEL_TSR);
   assign tcr_we   = do_write && (dec.sel == SEL_TCR);
   assign scr_we   = do_write && (dec.sel == SEL_SCR);

   // Scratch bank, architecturally zero after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < SCR_NUM; i++) begin
            scr[i] <= '0;
         end
      end else if (scr_we) begin
         scr[dec.idx] <= new_val;
      end
   end

   tsc_timer u_tsc (
      .clk     (clk),
      .rst     (rst),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .tsr_nxt (new_val),
      .tcr_nxt (new_val),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

   // Response, old value or bad address
   assign rsp_nxt.status = (dec.sel == SEL_NONE) ? ST_BAD_ADDR : ST_OK;
   assign rsp_nxt.value  = old_val;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= dec_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_valid) begin
         ex_rsp <= rsp_nxt;
      end
   end

endmodule

`default_nettype wire

/* msr_pkg.sv */
// ======================================
// Shared widths, MSR map, TCR fields and
// credit depths for the MSR access unit
// Imported by every block of the unit
// ======================================
`default_nettype none

package msr_pkg;

   // Register and address widths
   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 4;

   // TCR layout, compare field in the low bits
   localparam int TCR_CNT_W  = 29;
   localparam int TCR_EN_BIT = 29;
   localparam int TCR_I_BIT  = 30;
   localparam int TCR_P_BIT  = 31;

   // MSR address map
   localparam logic [ADDR_W-1:0] MSR_TSR  = 4'd0;
   localparam logic [ADDR_W-1:0] MSR_TCR  = 4'd1;
   localparam logic [ADDR_W-1:0] MSR_SCR0 = 4'd2;
   localparam int                SCR_NUM  = 4;
   localparam int                SCR_IW   = $clog2(SCR_NUM);

   // Flow control depths
   // Sender credits match the response queue depth
   localparam int CMD_CREDITS = 4;
   localparam int RSP_CREDITS = 2;

   // Derived counter widths
   localparam int QUEUE_AW  = $clog2(CMD_CREDITS);
   localparam int QCNT_W    = $clog2(CMD_CREDITS + 1);
   localparam int RSP_CNT_W = $clog2(RSP_CREDITS + 1);

   // Command opcodes
   typedef enum logic [1:0] {
      MSR_READ  = 2'd0,
      MSR_WRITE = 2'd1,
      MSR_SET   = 2'd2,   // OR with data
      MSR_CLR   = 2'd3    // AND with inverted data
   } msr_op_e;

   // Register select after decode
   typedef enum logic [1:0] {
      SEL_TSR  = 2'd0,
      SEL_TCR  = 2'd1,
      SEL_SCR  = 2'd2,
      SEL_NONE = 2'd3
   } msr_sel_e;

   // Response status
   typedef enum logic [0:0] {
      ST_OK       = 1'b0,
      ST_BAD_ADDR = 1'b1
   } msr_status_e;

   // Raw command from the sender
   typedef struct packed {
      msr_op_e             op;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
   } msr_cmd_t;

   // Decoded command
   typedef struct packed {
      msr_op_e             op;
      msr_sel_e            sel;
      logic [SCR_IW-1:0]   idx;
      logic [DATA_W-1:0]   wdata;
   } msr_dec_t;

   // Response, old register value plus status
   typedef struct packed {
      msr_status_e         status;
      logic [DATA_W-1:0]   value;
   } msr_rsp_t;

endpackage

`default_nettype wire

/* msr_result.sv */
// ======================================
// Result stage, response queue with
// response credits and command-credit return
// ======================================
`timescale 1ns/1ns
`default_nettype none

module msr_result (
   input  logic               clk,
   input  logic               rst,
   input  logic               ex_valid,
   input  msr_pkg::msr_rsp_t  ex_rsp,
   input  logic               rsp_credit,
   output logic               rsp_valid,
   output msr_pkg::msr_rsp_t  rsp,
   output logic               cmd_credit
);

   import msr_pkg::*;

   msr_rsp_t              q_mem [CMD_CREDITS];
   logic [QUEUE_AW-1:0]   wr_ptr;
   logic [QUEUE_AW-1:0]   rd_ptr;
   logic [QCNT_W-1:0]     q_cnt;
   logic [RSP_CNT_W-1:0]  crd_cnt;
   logic                  pop;

   // Head leaves when a response credit is held
   assign pop        = (q_cnt != '0) && (crd_cnt != '0);
   assign rsp_valid  = pop;
   assign rsp        = q_mem[rd_ptr];
   // Each departing response frees one sender slot
   assign cmd_credit = pop;

   // Queue storage, no overflow by credit sizing
   always_ff @(posedge clk) begin
      if (ex_valid) begin
         q_mem[wr_ptr] <= ex_rsp;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_cnt  <= '0;
      end else begin
         if (ex_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({ex_valid, pop})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;
         endcase
      end
   end

   // Response credits, return and spend may coincide
   always_ff @(posedge clk) begin
      if (rst) begin
         crd_cnt <= RSP_CNT_W'(RSP_CREDITS);
      end else begin
         case ({rsp_credit, pop})
            2'b10:   crd_cnt <= crd_cnt + 1'b1;
            2'b01:   crd_cnt <= crd_cnt - 1'b1;
            default: crd_cnt <= crd_cnt;
         endcase
      end
   end

endmodule

`default_nettype wire

/* msr_unit_top.sv */
// ======================================
// MSR access unit top level
// Decode, execute and result in a row
// ======================================
`timescale 1ns/1ns
`default_nettype none

module msr_unit_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               cmd_valid,
   input  msr_pkg::msr_cmd_t  cmd,
   output logic               cmd_credit,
   output logic               rsp_valid,
   output msr_pkg::msr_rsp_t  rsp,
   input  logic               rsp_credit,
   output logic               tsc_irq
);

   import msr_pkg::*;

   logic      dec_valid;
   msr_dec_t  dec;
   logic      ex_valid;
   msr_rsp_t  ex_rsp;

   msr_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .dec_valid (dec_valid),
      .dec       (dec)
   );

   msr_execute u_execute (
      .clk       (clk),
      .rst       (rst),
      .dec_valid (dec_valid),
      .dec       (dec),
      .ex_valid  (ex_valid),
      .ex_rsp    (ex_rsp),
      .tsc_irq   (tsc_irq)
   );

   msr_result u_result (
      .clk        (clk),
      .rst        (rst),
      .ex_valid   (ex_valid),
      .ex_rsp     (ex_rsp),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .cmd_credit (cmd_credit)
   );

endmodule

`default_nettype wire

/* tb_msr_unit.sv */
// ========================================
// Testbench for the MSR access unit
// Directed and random MSR commands with credit
// flow control, checked by a cycle model
// ========================================
`timescale 1ns/1ns
`default_nettype none

module tb_msr_unit;

   import msr_pkg::*;

   localparam int N_RAND = 400;
   // Directed commands on top of the random ones
   localparam int N_CMDS = N_RAND + 40;
   localparam int LIMIT  = 20 * N_CMDS + 200;

   logic      clk;
   logic      rst;
   logic      cmd_valid;
   msr_cmd_t  cmd;
   logic      cmd_credit;
   logic      rsp_valid;
   msr_rsp_t  rsp;
   logic      rsp_credit;
   logic      tsc_irq;

   // Reference state, as after the latest rising edge
   logic [DATA_W-1:0] m_tsr;
   logic [DATA_W-1:0] m_tcr;
   logic [DATA_W-1:0] m_scr [SCR_NUM];
   logic              m_irq;
   // Command sitting in decode this cycle
   logic              pend_valid;
   msr_cmd_t          pend_cmd;

   msr_rsp_t exp_q [$];
   int       ready_q [$];
   // Cycles at which the receiver frees a slot
   int       ret_q [$];
   int       cyc;
   int       wd_cycles;
   int       cmd_crd;
   int       rsp_crd;
   int       rsp_errs;
   int       irq_errs;
   int       flow_errs;
   int       other_errs;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   msr_unit_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_credit (cmd_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_credit (rsp_credit),
      .tsc_irq    (tsc_irq)
   );

   task automatic check_rsp(input msr_rsp_t got, input msr_rsp_t exp);
      if (got !== exp) begin
         rsp_errs++;
         $display("mismatch at %0t: response %s %h, expected %s %h", $time,
                  got.status.name(), got.value, exp.status.name(), exp.value);
      end
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp) begin
         irq_errs++;
         $display("mismatch at %0t: tsc_irq %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_flow(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         flow_errs++;
         $display("mismatch at %0t: %s %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic print_counts();
      $display("errors: response %0d, interrupt %0d, flow %0d, other %0d",
               rsp_errs, irq_errs, flow_errs, other_errs);
   endtask

   // One clock of the reference, the decode command executes now
   task automatic model_cycle();
      logic [DATA_W-1:0] old_v;
      logic [DATA_W-1:0] new_v;
      logic [DATA_W-1:0] tcr_eff;
      logic              bad;
      logic              tsr_we;
      logic              tcr_we;
      logic              hit;
      msr_rsp_t          exp;
      old_v  = '0;
      new_v  = '0;
      tsr_we = 1'b0;
      tcr_we = 1'b0;
      if (pend_valid) begin
         bad = pend_cmd.addr >= MSR_SCR0 + SCR_NUM;
         if (pend_cmd.addr == MSR_TSR)
            old_v = m_tsr;
         else if (pend_cmd.addr == MSR_TCR)
            old_v = {m_irq, m_tcr[TCR_P_BIT-1:0]};
         else if (!bad)
            old_v = m_scr[pend_cmd.addr - MSR_SCR0];
         case (pend_cmd.op)
            MSR_WRITE: new_v = pend_cmd.wdata;
            MSR_SET:   new_v = old_v | pend_cmd.wdata;
            MSR_CLR:   new_v = old_v & ~pend_cmd.wdata;
            default:   new_v = old_v;
         endcase
         exp.status = bad ? ST_BAD_ADDR : ST_OK;
         exp.value  = bad ? '0 : old_v;
         exp_q.push_back(exp);
         // Queued two cycles after execute
         ready_q.push_back(cyc + 2);
         if (pend_cmd.op != MSR_READ && !bad) begin
            tsr_we = pend_cmd.addr == MSR_TSR;
            tcr_we = pend_cmd.addr == MSR_TCR;
            if (!tsr_we && !tcr_we)
               m_scr[pend_cmd.addr - MSR_SCR0] = new_v;
         end
      end
      // TCR write counts from its own cycle
      tcr_eff = tcr_we ? new_v : {m_irq, m_tcr[TCR_P_BIT-1:0]};
      hit = (m_tsr[TCR_CNT_W-1:0] == tcr_eff[TCR_CNT_W-1:0]) && tcr_eff[TCR_I_BIT];
      m_irq = (m_irq || hit) && !(tcr_we && !new_v[TCR_P_BIT]);
      if (tsr_we)
         m_tsr = new_v;
      else if (tcr_eff[TCR_EN_BIT])
         m_tsr = m_tsr + 1;
      if (tcr_we)
         m_tcr = new_v;
   endtask

   // Sample at the falling edge, then drive the next inputs
   task automatic run_cycle(input logic send, input msr_cmd_t c, output logic sent);
      logic exp_pop;
      @(negedge clk);
      cyc++;
      exp_pop = (exp_q.size() > 0) && (ready_q[0] <= cyc) && (rsp_crd > 0);
      check_flow(rsp_valid, exp_pop, "rsp_valid");
      check_flow(cmd_credit, exp_pop, "cmd_credit");
      check_irq(tsc_irq, m_irq);
      if (rsp_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            other_errs++;
            $display("response at %0t with no command outstanding", $time);
         end else begin
            check_rsp(rsp, exp_q.pop_front());
            void'(ready_q.pop_front());
         end
         rsp_crd--;
         ret_q.push_back(cyc + $urandom_range(0, 5));
      end
      if (cmd_credit === 1'b1) begin
         if (cmd_crd >= CMD_CREDITS) begin
            other_errs++;
            $display("command credit at %0t beyond the commands sent", $time);
         end else begin
            cmd_crd++;
         end
      end
      model_cycle();
      // Receiver stalls for 50 of every 200 cycles
      if ((cyc % 200) < 150 && ret_q.size() > 0 && ret_q[0] <= cyc) begin
         void'(ret_q.pop_front());
         rsp_credit = 1'b1;
         rsp_crd++;
      end else begin
         rsp_credit = 1'b0;
      end
      sent       = send && (cmd_crd > 0);
      cmd_valid  = sent;
      cmd        = sent ? c : '0;
      if (sent)
         cmd_crd--;
      pend_valid = sent;
      pend_cmd   = c;
   endtask

   task automatic send_cmd(input msr_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
      msr_cmd_t c;
      logic     sent;
      c.op    = op;
      c.addr  = addr;
      c.wdata = data;
      sent    = 1'b0;
      while (!sent)
         run_cycle(1'b1, c, sent);
   endtask

   task automatic idle_cycles(input int n);
      logic sent;
      repeat (n) run_cycle(1'b0, '0, sent);
   endtask

   // Run limit, counted on the clock
   initial begin
      wd_cycles = 0;
      while (wd_cycles < LIMIT) begin
         @(posedge clk);
         wd_cycles++;
      end
      $display("timeout after %0d cycles, %0d responses missing", wd_cycles, exp_q.size());
      print_counts();
      $display("Checks failed");
      $finish;
   end

   initial begin : stim
      logic [DATA_W-1:0] tcr_v;
      logic [DATA_W-1:0] data;
      logic [ADDR_W-1:0] addr;
      msr_op_e           op;
      int                waited;
      void'($urandom(55));
      rst        = 1'b1;
      cmd_valid  = 1'b0;
      cmd        = '0;
      rsp_credit = 1'b0;
      m_tsr      = '0;
      m_tcr      = '0;
      m_irq      = 1'b0;
      for (int i = 0; i < SCR_NUM; i++)
         m_scr[i] = '0;
      pend_valid = 1'b0;
      pend_cmd   = '0;
      cyc        = 0;
      cmd_crd    = CMD_CREDITS;
      rsp_crd    = RSP_CREDITS;
      rsp_errs   = 0;
      irq_errs   = 0;
      flow_errs  = 0;
      other_errs = 0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      // Quiet outputs, then every register reads zero
      idle_cycles(4);
      for (int a = 0; a < MSR_SCR0 + SCR_NUM; a++)
         send_cmd(MSR_READ, ADDR_W'(a), '1);
      // Scratch read-modify-write
      send_cmd(MSR_WRITE, 4'd2, 32'hA5A5_0F0F);
      send_cmd(MSR_SET, 4'd2, 32'h0000_F0F0);
      send_cmd(MSR_CLR, 4'd2, 32'hA000_0001);
      send_cmd(MSR_WRITE, 4'd5, 32'h1357_9BDF);
      send_cmd(MSR_READ, 4'd2, '0);
      // Unmapped addresses, bank untouched
      send_cmd(MSR_WRITE, 4'd6, '1);
      send_cmd(MSR_SET, 4'd15, '1);
      send_cmd(MSR_READ, 4'd5, '0);
      // TSR holds with counter off
      send_cmd(MSR_WRITE, MSR_TSR, 32'h1234_5678);
      send_cmd(MSR_READ, MSR_TSR, '0);
      tcr_v = '0;
      tcr_v[TCR_EN_BIT] = 1'b1;
      send_cmd(MSR_WRITE, MSR_TCR, tcr_v);
      idle_cycles(3);
      send_cmd(MSR_READ, MSR_TSR, '0);
      // Compare match some 30 counts ahead
      send_cmd(MSR_WRITE, MSR_TSR, 32'h0000_0100);
      tcr_v[TCR_I_BIT] = 1'b1;
      tcr_v[TCR_CNT_W-1:0] = 29'h120;
      send_cmd(MSR_WRITE, MSR_TCR, tcr_v);
      waited = 0;
      while (tsc_irq !== 1'b1 && waited < 100) begin
         idle_cycles(1);
         waited++;
      end
      if (tsc_irq !== 1'b1) begin
         other_errs++;
         $display("interrupt did not rise after the compare match");
      end
      idle_cycles(8);
      send_cmd(MSR_READ, MSR_TCR, '0);
      // P low clears, IE off keeps it clear
      tcr_v[TCR_I_BIT] = 1'b0;
      tcr_v[TCR_P_BIT] = 1'b0;
      send_cmd(MSR_WRITE, MSR_TCR, tcr_v);
      send_cmd(MSR_READ, MSR_TCR, '0);
      idle_cycles(4);
      if (tsc_irq !== 1'b0) begin
         other_errs++;
         $display("interrupt still high after writing P low");
      end
      for (int n = 0; n < N_RAND; n++) begin
         op = msr_op_e'($urandom_range(0, 3));
         if ($urandom_range(0, 9) < 8)
            addr = ADDR_W'($urandom_range(0, 5));
         else
            addr = ADDR_W'($urandom_range(6, 15));
         data = $urandom();
         // Compare field near the live count so matches occur
         if (addr == MSR_TCR)
            data[TCR_CNT_W-1:0] = m_tsr[TCR_CNT_W-1:0] + TCR_CNT_W'($urandom_range(0, 30));
         send_cmd(op, addr, data);
         if ($urandom_range(0, 7) == 0)
            idle_cycles($urandom_range(1, 6));
      end
      // Drain the queue
      while (exp_q.size() > 0)
         idle_cycles(1);
      idle_cycles(10);
      print_counts();
      if (rsp_errs + irq_errs + flow_errs + other_errs == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tsc_timer.sv */
// ======================================
// Time-stamp counter with TSR, TCR and
// the compare interrupt, driven by execute
// ======================================
`timescale 1ns/1ns
`default_nettype none

module tsc_timer (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       tsr_we,
   input  logic                       tcr_we,
   input  logic [msr_pkg::DATA_W-1:0] tsr_nxt,
   input  logic [msr_pkg::DATA_W-1:0] tcr_nxt,
   output logic [msr_pkg::DATA_W-1:0] tsr,
   output logic [msr_pkg::DATA_W-1:0] tcr,
   output logic                       tsc_irq
);

   import msr_pkg::*;

   // Stored TCR without the pending bit
   logic [TCR_P_BIT-1:0]  tcr_r;
   // TCR as seen by counter and compare
   logic [DATA_W-1:0]     tcr_eff;
   logic [TCR_CNT_W-1:0]  tcr_cnt;
   logic                  tcr_en;
   logic                  tcr_i;
   logic                  irq_set;
   logic                  irq_clr;

   // Pending bit reads back as the live interrupt
   assign tcr = {tsc_irq, tcr_r};

   // Same-cycle write bypass
   assign tcr_eff = tcr_we ? tcr_nxt : tcr;
   assign tcr_cnt = tcr_eff[TCR_CNT_W-1:0];
   assign tcr_en  = tcr_eff[TCR_EN_BIT];
   assign tcr_i   = tcr_eff[TCR_I_BIT];

   always_ff @(posedge clk) begin
      if (rst) begin
         tcr_r <= '0;
      end else if (tcr_we) begin
         tcr_r <= tcr_nxt[TCR_P_BIT-1:0];
      end
   end

   // Write beats counting
   always_ff @(posedge clk) begin
      if (rst) begin
         tsr <= '0;
      end else if (tsr_we) begin
         tsr <= tsr_nxt;
      end else if (tcr_en) begin
         tsr <= tsr + 1'b1;
      end
   end

   // Compare on the low part of TSR
   assign irq_set = (tsr[TCR_CNT_W-1:0] == tcr_cnt) & tcr_i;
   // Software clears by writing P low
   assign irq_clr = tcr_we & ~tcr_nxt[TCR_P_BIT];

   // Sticky until cleared, clear wins
   always_ff @(posedge clk) begin
      if (rst) begin
         tsc_irq <= 1'b0;
      end else begin
         tsc_irq <= (tsc_irq | irq_set) & ~irq_clr;
      end
   end

endmodule

`default_nettype wire
